/* core_sva.sv */
`timescale 1ns/10ps

module core_sva #(
    parameter int ISSUE_WIDTH = 2
) (
    input logic                                       clk,
    input logic                                       rst,
    input logic [ISSUE_WIDTH*cpu_pkg::INSN_W-1:0]     insn_i,
    input logic [ISSUE_WIDTH-1:0]                     insn_accept_i,
    input logic [ISSUE_WIDTH-1:0]                     wb_valid_i,
    input logic [ISSUE_WIDTH*cpu_pkg::REG_ADDR_W-1:0] wb_rd_i
);
    import cpu_pkg::*;

    insn_t [ISSUE_WIDTH-1:0]                lane;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] wb_rd;
    logic [ISSUE_WIDTH-1:0]                 acc_wr;
    logic [ISSUE_WIDTH-1:0]                 cross_hz;
    logic [ISSUE_WIDTH-1:0]                 flight_hz;
    logic [ISSUE_WIDTH-1:0]                 wr_hist [3];
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] rd_hist [3];
    logic                                   seen_write;
    int unsigned                            fail_count = 0;

    assign lane = insn_i;
    assign wb_rd = wb_rd_i;

    function automatic logic legal_alu(insn_t w);
        if (w.r.opcode == OPC_OP) begin
            return w.r.funct7 == F7_BASE || (w.r.funct7 == F7_ALT && w.r.funct3 == F3_ADD_SUB);
        end
        if (w.i.opcode == OPC_OP_IMM) begin
            return !(w.i.funct3 inside {F3_SLL, F3_SRL}) || w.r.funct7 == F7_BASE;
        end
        return 1'b0;
    endfunction

    // rs2 is a source only for register-register words
    function automatic logic uses_reg(insn_t w, logic [REG_ADDR_W-1:0] r);
        return r != '0 && (w.i.rs1 == r || (w.r.opcode == OPC_OP && w.r.rs2 == r));
    endfunction

    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            acc_wr[k] = insn_accept_i[k] && legal_alu(lane[k]) && lane[k].r.rd != '0;
        end
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            cross_hz[k] = 1'b0;
            flight_hz[k] = 1'b0;
            for (int j = 0; j < ISSUE_WIDTH; j++) begin
                if (j < k && acc_wr[j] && uses_reg(lane[k], lane[j].r.rd)) begin
                    cross_hz[k] = 1'b1;
                end
                for (int d = 0; d < 2; d++) begin
                    if (wr_hist[d][j] && uses_reg(lane[k], rd_hist[d][j])) begin
                        flight_hz[k] = 1'b1;
                    end
                end
            end
        end
    end

    // accepted writes of the last three cycles, as seen at the ports
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int d = 0; d < 3; d++) begin
                wr_hist[d] <= '0;
                rd_hist[d] <= '0;
            end
            seen_write <= 1'b0;
        end else begin
            wr_hist[0] <= acc_wr;
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                rd_hist[0][k] <= lane[k].r.rd;
            end
            wr_hist[1] <= wr_hist[0];
            rd_hist[1] <= rd_hist[0];
            wr_hist[2] <= wr_hist[1];
            rd_hist[2] <= rd_hist[1];
            if (|acc_wr) begin
                seen_write <= 1'b1;
            end
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !seen_write |-> wb_valid_i == '0)
        else begin
            fail_count++;
            $error("writeback before any accepted write");
        end

    for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : g_lane
        a_wb_latency: assert property (@(posedge clk) disable iff (rst)
            wb_valid_i[k] == wr_hist[2][k])
            else begin
                fail_count++;
                $error("lane %0d writeback does not follow an accepted write", k);
            end

        a_wb_rd: assert property (@(posedge clk) disable iff (rst)
            wb_valid_i[k] |-> wb_rd[k] == rd_hist[2][k])
            else begin
                fail_count++;
                $error("lane %0d writeback rd differs from the issued rd", k);
            end

        a_wb_not_x0: assert property (@(posedge clk) disable iff (rst)
            wb_valid_i[k] |-> wb_rd[k] != '0)
            else begin
                fail_count++;
                $error("lane %0d writes back to x0", k);
            end

        a_no_flight_hazard: assert property (@(posedge clk) disable iff (rst)
            insn_accept_i[k] |-> !flight_hz[k])
            else begin
                fail_count++;
                $error("lane %0d accepted over an in-flight destination", k);
            end

        if (k > 0) begin : g_upper
            a_in_order: assert property (@(posedge clk) disable iff (rst)
                insn_accept_i[k] |-> insn_accept_i[k-1])
                else begin
                    fail_count++;
                    $error("lane %0d accepted while lane %0d rejected", k, k - 1);
                end

            a_no_cross_hazard: assert property (@(posedge clk) disable iff (rst)
                insn_accept_i[k] |-> !cross_hz[k])
                else begin
                    fail_count++;
                    $error("lane %0d accepted reading a lower lane destination", k);
                end
        end
    end

endmodule

bind superscalar_core core_sva #(.ISSUE_WIDTH(ISSUE_WIDTH)) core_sva_i (
    .clk           (clk),
    .rst           (rst),
    .insn_i        (insn_i),
    .insn_accept_i (insn_accept_o),
    .wb_valid_i    (wb_valid_o),
    .wb_rd_i       (wb_rd_o)
);

/* core_tb.sv */
`timescale 1ns/10ps

module core_tb;
    import cpu_pkg::*;

    localparam int ISSUE_WIDTH = 2;
    localparam int RUN_CYCLES = 2000;
    localparam int IDLE_LIMIT = 40;
    localparam int DRAIN_LIMIT = 20;

    logic                              clk;
    logic                              rst;
    logic [ISSUE_WIDTH*INSN_W-1:0]     insn;
    logic [ISSUE_WIDTH-1:0]            insn_valid;
    logic [ISSUE_WIDTH-1:0]            insn_accept;
    logic [ISSUE_WIDTH-1:0]            wb_valid;
    logic [ISSUE_WIDTH*REG_ADDR_W-1:0] wb_rd;
    logic [ISSUE_WIDTH*XLEN-1:0]       wb_data;

    logic [31:0]     rng_state;
    logic [4:0]      recent_rd [4];
    logic [XLEN-1:0] model_regs [NUM_REGS];
    logic [31:0]     pend [$];
    int              exp_lane [$];
    logic [4:0]      exp_rd [$];
    logic [XLEN-1:0] exp_data [$];
    int              errors;
    int              idle_cycles;
    bit              first_wb_done;
    bit              timed_out;

    superscalar_core #(.ISSUE_WIDTH(ISSUE_WIDTH)) superscalar_core_i (
        .clk           (clk),
        .rst           (rst),
        .insn_i        (insn),
        .insn_valid_i  (insn_valid),
        .insn_accept_o (insn_accept),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

    always #2 clk = ~clk;

    function automatic logic [15:0] rand16();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];
    endfunction

    // roughly one source in three reuses a recent destination
    function automatic logic [4:0] pick_src();
        logic [15:0] r;
        r = rand16();
        if (r[7:0] < 8'd85) begin
            return recent_rd[r[9:8]];
        end
        return r[14:10];
    endfunction

    function automatic logic [31:0] make_insn();
        logic [15:0] r;
        logic [15:0] imm_bits;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [31:0] w;
        r = rand16();
        imm_bits = rand16();
        rs1 = pick_src();
        rs2 = pick_src();
        rd = (r[2:0] == 3'd0) ? 5'd0 : r[7:3];
        f3 = (r[10:8] == 3'b011) ? F3_SLT : r[10:8];
        imm = imm_bits[11:0];
        if (r[15:12] == 4'd0) begin
            // branch opcode, not supported by the core
            w[31:16] = rand16();
            w[15:0] = rand16();
            w[6:0] = 7'b1100011;
        end else if (r[11]) begin
            w = {(f3 == F3_ADD_SUB && r[12]) ? F7_ALT : F7_BASE, rs2, rs1, f3, rd, OPC_OP};
        end else begin
            if (f3 inside {F3_SLL, F3_SRL}) begin
                imm[11:5] = 7'd0;
            end
            w = {imm, rs1, f3, rd, OPC_OP_IMM};
        end
        if (rd != 5'd0) begin
            recent_rd[3] = recent_rd[2];
            recent_rd[2] = recent_rd[1];
            recent_rd[1] = recent_rd[0];
            recent_rd[0] = rd;
        end
        return w;
    endfunction

    function automatic logic [XLEN-1:0] expected_result(logic [31:0] w);
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        opc = w[6:0];
        f3 = w[14:12];
        a = model_regs[w[19:15]];
        if (opc == OPC_OP) begin
            b = model_regs[w[24:20]];
        end else if (f3 inside {F3_XOR, F3_OR, F3_AND}) begin
            b = {20'd0, w[31:20]};
        end else begin
            b = {{20{w[31]}}, w[31:20]};
        end
        case (f3)
            F3_ADD_SUB: return (opc == OPC_OP && w[30]) ? a - b : a + b;
            F3_SLL: return a << b[4:0];
            F3_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR: return a ^ b;
            F3_SRL: return a >> b[4:0];
            F3_OR: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic drive_lanes();
        logic [15:0] r;
        int          n_valid;
        while (pend.size() < ISSUE_WIDTH) begin
            pend.push_back(make_insn());
        end
        r = rand16();
        n_valid = (r[3:0] == 4'd0) ? int'(r[9:8]) % (ISSUE_WIDTH + 1) : ISSUE_WIDTH;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            insn[k*INSN_W +: INSN_W] = pend[k];
            insn_valid[k] = (k < n_valid);
        end
    endtask

    // writebacks first, so the model is current for this cycle's reads
    task automatic check_cycle();
        int              n_acc;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
        logic [31:0]     w;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            if (wb_valid[k]) begin
                rd = wb_rd[k*REG_ADDR_W +: REG_ADDR_W];
                data = wb_data[k*XLEN +: XLEN];
                if (exp_rd.size() == 0) begin
                    errors++;
                    $display("writeback on lane %0d with no instruction outstanding", k);
                end else begin
                    assert (exp_lane[0] == k) else begin
                        errors++;
                        $display("ERROR wb_valid_o: lane %h expected lane %h", k, exp_lane[0]);
                    end
                    assert (rd == exp_rd[0]) else begin
                        errors++;
                        $display("ERROR wb_rd_o[%0d]: got %h expected %h", k, rd, exp_rd[0]);
                    end
                    assert (data == exp_data[0]) else begin
                        errors++;
                        $display("ERROR wb_data_o[%0d]: got %h expected %h", k, data,
                                 exp_data[0]);
                    end
                    model_regs[exp_rd[0]] = exp_data[0];
                    void'(exp_lane.pop_front());
                    void'(exp_rd.pop_front());
                    void'(exp_data.pop_front());
                end
                if (!first_wb_done) begin
                    assert (data == '0) else begin
                        errors++;
                        $display("ERROR wb_data_o[%0d]: got %h expected %h after reset",
                                 k, data, 32'd0);
                    end
                end
            end
        end
        if (|wb_valid) begin
            first_wb_done = 1'b1;
        end
        n_acc = 0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            if (insn_accept[k]) begin
                assert (insn_valid[k]) else begin
                    errors++;
                    $display("lane %0d was accepted without a valid word", k);
                end
                if (k < pend.size()) begin
                    w = pend[k];
                    // generated words for both opcodes always carry a legal function
                    if ((w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM) && w[11:7] != 5'd0) begin
                        exp_lane.push_back(k);
                        exp_rd.push_back(w[11:7]);
                        exp_data.push_back(expected_result(w));
                    end
                    n_acc++;
                end
            end
        end
        repeat (n_acc) void'(pend.pop_front());
        idle_cycles = (n_acc == 0) ? idle_cycles + 1 : 0;
    endtask

    initial begin
        int drain_cycles;
        int sva_fails;
        clk = 1'b0;
        rst = 1'b1;
        insn = '0;
        insn_valid = '0;
        rng_state = 32'd49348;
        errors = 0;
        idle_cycles = 0;
        first_wb_done = 1'b0;
        timed_out = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            recent_rd[i] = 5'(i + 1);
        end
        // first group only reads registers, both results are zero
        pend.push_back({F7_BASE, 5'd11, 5'd10, F3_OR, 5'd3, OPC_OP});
        pend.push_back({F7_BASE, 5'd13, 5'd12, F3_ADD_SUB, 5'd4, OPC_OP});
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int cyc = 0; cyc < RUN_CYCLES && !timed_out; cyc++) begin
            drive_lanes();
            #1;
            check_cycle();
            if (idle_cycles > IDLE_LIMIT) begin
                $display("no instruction was accepted for %0d cycles", IDLE_LIMIT);
                timed_out = 1'b1;
            end
            @(negedge clk);
        end
        insn_valid = '0;
        drain_cycles = 0;
        while (exp_rd.size() != 0 && !timed_out) begin
            #1;
            check_cycle();
            @(negedge clk);
            drain_cycles++;
            if (drain_cycles > DRAIN_LIMIT && exp_rd.size() != 0) begin
                $display("%0d writebacks still missing after the pipeline drained",
                         exp_rd.size());
                timed_out = 1'b1;
            end
        end
        sva_fails = superscalar_core_i.core_sva_i.fail_count;
        $display("%0d testbench errors, %0d assertion failures, timeout %0d",
                 errors, sva_fails, timed_out);
        if (errors == 0 && sva_fails == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS = 32;
    localparam int INSN_W = 32;
    localparam int IMM_W = 12;
    localparam int SHAMT_W = $clog2(XLEN);

    // accepted opcodes
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_op_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    typedef struct packed {
        logic [IMM_W-1:0]      imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    // same word, two layouts
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } insn_t;

endpackage

/* execute_lanes.sv */
`timescale 1ns/10ps

module execute_lanes #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    decode_execute_if.sink   dx,
    execute_result_if.source xr
);
    import cpu_pkg::*;

    logic [ISSUE_WIDTH-1:0][XLEN-1:0] alu_result;

    function automatic logic [XLEN-1:0] alu_eval(
        alu_op_e         op,
        logic [XLEN-1:0] a,
        logic [XLEN-1:0] b
    );
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR: return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            // shift amount from low bits only
            ALU_SLL: return a << b[SHAMT_W-1:0];
            ALU_SRL: return a >> b[SHAMT_W-1:0];
            default: return '0;
        endcase
    endfunction

    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            alu_result[k] = alu_eval(dx.alu_op[k], dx.operand_a[k], dx.operand_b[k]);
        end
    end

    // bubbles drop out here
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xr.valid <= '0;
        end else begin
            xr.valid <= dx.valid & dx.writes;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            xr.rd[k] <= dx.rd[k];
            xr.result[k] <= alu_result[k];
        end
    end

endmodule

/* issue_decode.sv */
`timescale 1ns/10ps

module issue_decode #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  cpu_pkg::insn_t [ISSUE_WIDTH-1:0]                insn_i,
    input  logic [ISSUE_WIDTH-1:0]                          insn_valid_i,
    output logic [ISSUE_WIDTH-1:0]                          insn_accept_o,
    output logic [ISSUE_WIDTH-1:0][cpu_pkg::REG_ADDR_W-1:0] rd_addr_a_o,
    output logic [ISSUE_WIDTH-1:0][cpu_pkg::REG_ADDR_W-1:0] rd_addr_b_o,
    input  logic [ISSUE_WIDTH-1:0][cpu_pkg::XLEN-1:0]       rd_data_a_i,
    input  logic [ISSUE_WIDTH-1:0][cpu_pkg::XLEN-1:0]       rd_data_b_i,
    decode_execute_if.source                                dx,
    execute_result_if.monitor                               inflight
);
    import cpu_pkg::*;

    alu_op_e [ISSUE_WIDTH-1:0]        dec_op;
    logic [ISSUE_WIDTH-1:0]           dec_legal;
    logic [ISSUE_WIDTH-1:0]           dec_zext;
    logic [ISSUE_WIDTH-1:0]           dec_writes;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0] dec_operand_b;
    logic [ISSUE_WIDTH-1:0]           sb_hit;
    logic [ISSUE_WIDTH-1:0]           cross_hit;
    logic [ISSUE_WIDTH-1:0]           accept;

    // rs1 always counts, rs2 only for register-register words
    function automatic logic reads_reg(insn_t w, logic [REG_ADDR_W-1:0] r);
        return (r != '0) && (w.r.rs1 == r || (w.r.opcode == OPC_OP && w.r.rs2 == r));
    endfunction

    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            rd_addr_a_o[k] = insn_i[k].r.rs1;
            rd_addr_b_o[k] = insn_i[k].r.rs2;
        end
    end

    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            dec_op[k] = ALU_ADD;
            dec_legal[k] = 1'b0;
            dec_zext[k] = 1'b0;
            if (insn_i[k].r.opcode == OPC_OP) begin
                dec_legal[k] = insn_i[k].r.funct7 == F7_BASE;
                case (insn_i[k].r.funct3)
                    F3_ADD_SUB: begin
                        dec_legal[k] = insn_i[k].r.funct7 inside {F7_BASE, F7_ALT};
                        dec_op[k] = (insn_i[k].r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    end
                    F3_SLL: dec_op[k] = ALU_SLL;
                    F3_SLT: dec_op[k] = ALU_SLT;
                    F3_XOR: dec_op[k] = ALU_XOR;
                    F3_SRL: dec_op[k] = ALU_SRL;
                    F3_OR: dec_op[k] = ALU_OR;
                    F3_AND: dec_op[k] = ALU_AND;
                    default: dec_legal[k] = 1'b0;
                endcase
            end else if (insn_i[k].i.opcode == OPC_OP_IMM) begin
                dec_legal[k] = 1'b1;
                // logic immediates are zero extended
                dec_zext[k] = insn_i[k].i.funct3 inside {F3_XOR, F3_OR, F3_AND};
                case (insn_i[k].i.funct3)
                    F3_ADD_SUB: dec_op[k] = ALU_ADD;
                    F3_SLT: dec_op[k] = ALU_SLT;
                    F3_XOR: dec_op[k] = ALU_XOR;
                    F3_OR: dec_op[k] = ALU_OR;
                    F3_AND: dec_op[k] = ALU_AND;
                    // upper imm bits of a shift read as funct7
                    F3_SLL: begin
                        dec_op[k] = ALU_SLL;
                        dec_legal[k] = insn_i[k].r.funct7 == F7_BASE;
                    end
                    F3_SRL: begin
                        dec_op[k] = ALU_SRL;
                        dec_legal[k] = insn_i[k].r.funct7 == F7_BASE;
                    end
                    default: dec_legal[k] = 1'b0;
                endcase
            end
            dec_writes[k] = dec_legal[k] && insn_i[k].r.rd != '0;
            if (insn_i[k].r.opcode == OPC_OP) begin
                dec_operand_b[k] = rd_data_b_i[k];
            end else if (dec_zext[k]) begin
                dec_operand_b[k] = {{(XLEN-IMM_W){1'b0}}, insn_i[k].i.imm12};
            end else begin
                dec_operand_b[k] = {{(XLEN-IMM_W){insn_i[k].i.imm12[IMM_W-1]}},
                                    insn_i[k].i.imm12};
            end
        end
    end

    // scoreboard over both in-flight stages, cross check against lower lanes
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            sb_hit[k] = 1'b0;
            cross_hit[k] = 1'b0;
            for (int j = 0; j < ISSUE_WIDTH; j++) begin
                if (dx.valid[j] && dx.writes[j] && reads_reg(insn_i[k], dx.rd[j])) begin
                    sb_hit[k] = 1'b1;
                end
                if (inflight.valid[j] && reads_reg(insn_i[k], inflight.rd[j])) begin
                    sb_hit[k] = 1'b1;
                end
                if (j < k && dec_writes[j] && reads_reg(insn_i[k], insn_i[j].r.rd)) begin
                    cross_hit[k] = 1'b1;
                end
            end
        end
    end

    // in-order prefix
    always_comb begin
        logic chain;
        chain = 1'b1;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            accept[k] = chain && insn_valid_i[k] && !sb_hit[k] && !cross_hit[k];
            chain = accept[k];
        end
    end

    assign insn_accept_o = accept;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dx.valid <= '0;
            dx.writes <= '0;
        end else begin
            dx.valid <= accept;
            dx.writes <= accept & dec_writes;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            dx.rd[k] <= insn_i[k].r.rd;
            dx.alu_op[k] <= dec_op[k];
            dx.operand_a[k] <= rd_data_a_i[k];
            dx.operand_b[k] <= dec_operand_b[k];
        end
    end

endmodule

/* pipe_if.sv */
`timescale 1ns/10ps

// decoded lanes with operands, one entry per lane
interface decode_execute_if #(
    parameter int ISSUE_WIDTH = 2
);
    import cpu_pkg::*;

    logic [ISSUE_WIDTH-1:0]                 valid;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] rd;
    alu_op_e [ISSUE_WIDTH-1:0]              alu_op;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       operand_a;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       operand_b;
    logic [ISSUE_WIDTH-1:0]                 writes;

    modport source (output valid, rd, alu_op, operand_a, operand_b, writes);
    modport sink (input valid, rd, alu_op, operand_a, operand_b, writes);
endinterface

// alu results on their way to the register file
interface execute_result_if #(
    parameter int ISSUE_WIDTH = 2
);
    import cpu_pkg::*;

    logic [ISSUE_WIDTH-1:0]                 valid;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] rd;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       result;

    modport source (output valid, rd, result);
    modport sink (input valid, rd, result);
    // scoreboard view from issue
    modport monitor (input valid, rd);
endinterface

/* run.sh */
#!/bin/sh
# build and run core_tb with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module core_tb -f verilog.f -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench reaches its summary
./obj_dir/core_tb_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    exit 0
fi
exit 1

/* superscalar_core.sv */
`timescale 1ns/10ps

module superscalar_core #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [ISSUE_WIDTH*cpu_pkg::INSN_W-1:0]        insn_i,
    input  logic [ISSUE_WIDTH-1:0]                        insn_valid_i,
    output logic [ISSUE_WIDTH-1:0]                        insn_accept_o,
    output logic [ISSUE_WIDTH-1:0]                        wb_valid_o,
    output logic [ISSUE_WIDTH*cpu_pkg::REG_ADDR_W-1:0]    wb_rd_o,
    output logic [ISSUE_WIDTH*cpu_pkg::XLEN-1:0]          wb_data_o
);
    import cpu_pkg::*;

    insn_t [ISSUE_WIDTH-1:0]                insn_lane;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] rd_addr_a;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] rd_addr_b;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       rd_data_a;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       rd_data_b;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] wb_rd;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       wb_data;

    // lane k sits at bits [k*32 +: 32]
    assign insn_lane = insn_i;
    assign wb_rd_o = wb_rd;
    assign wb_data_o = wb_data;

    decode_execute_if #(.ISSUE_WIDTH(ISSUE_WIDTH)) dx_if ();
    execute_result_if #(.ISSUE_WIDTH(ISSUE_WIDTH)) xr_if ();

    issue_decode #(.ISSUE_WIDTH(ISSUE_WIDTH)) issue_decode_i (
        .clk           (clk),
        .rst           (rst),
        .insn_i        (insn_lane),
        .insn_valid_i  (insn_valid_i),
        .insn_accept_o (insn_accept_o),
        .rd_addr_a_o   (rd_addr_a),
        .rd_addr_b_o   (rd_addr_b),
        .rd_data_a_i   (rd_data_a),
        .rd_data_b_i   (rd_data_b),
        .dx            (dx_if.source),
        .inflight      (xr_if.monitor)
    );

    execute_lanes #(.ISSUE_WIDTH(ISSUE_WIDTH)) execute_lanes_i (
        .clk (clk),
        .rst (rst),
        .dx  (dx_if.sink),
        .xr  (xr_if.source)
    );

    writeback_regfile #(.ISSUE_WIDTH(ISSUE_WIDTH)) writeback_regfile_i (
        .clk         (clk),
        .rst         (rst),
        .rd_addr_a_i (rd_addr_a),
        .rd_addr_b_i (rd_addr_b),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b),
        .xr          (xr_if.sink),
        .wb_valid_o  (wb_valid_o),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data)
    );

endmodule

/* verilog.f */
cpu_pkg.sv
pipe_if.sv
issue_decode.sv
execute_lanes.sv
writeback_regfile.sv
superscalar_core.sv
core_sva.sv
core_tb.sv

/* writeback_regfile.sv */
`timescale 1ns/10ps

module writeback_regfile #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [ISSUE_WIDTH-1:0][cpu_pkg::REG_ADDR_W-1:0] rd_addr_a_i,
    input  logic [ISSUE_WIDTH-1:0][cpu_pkg::REG_ADDR_W-1:0] rd_addr_b_i,
    output logic [ISSUE_WIDTH-1:0][cpu_pkg::XLEN-1:0]       rd_data_a_o,
    output logic [ISSUE_WIDTH-1:0][cpu_pkg::XLEN-1:0]       rd_data_b_o,
    execute_result_if.sink                                  xr,
    output logic [ISSUE_WIDTH-1:0]                          wb_valid_o,
    output logic [ISSUE_WIDTH-1:0][cpu_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [ISSUE_WIDTH-1:0][cpu_pkg::XLEN-1:0]       wb_data_o
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // ascending lane order, so a later lane would win on the same rd
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (xr.valid[k] && xr.rd[k] != '0) begin
                    regs[xr.rd[k]] <= xr.result[k];
                end
            end
        end
    end

    // x0 reads zero
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            rd_data_a_o[k] = (rd_addr_a_i[k] == '0) ? '0 : regs[rd_addr_a_i[k]];
            rd_data_b_o[k] = (rd_addr_b_i[k] == '0) ? '0 : regs[rd_addr_b_i[k]];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid_o <= '0;
        end else begin
            wb_valid_o <= xr.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o <= xr.rd;
        wb_data_o <= xr.result;
    end

endmodule
